/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_uncore_lite
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cfg_regs.sv */
`default_nettype none

`include "uncore_config.svh"

module cfg_regs
  (input  wire                      clk_i
   , input  wire                    reset_i

   , input  wire                    cmd_v_i
   , input  wire uncore_pkg::msg_op_e cmd_op_i
   , input  wire uncore_pkg::paddr_t  cmd_addr_i
   , input  wire uncore_pkg::word_t   cmd_data_i
   , output logic                   cmd_ready_o

   , output logic                   resp_v_o
   , output uncore_pkg::word_t      resp_data_o
   , input  wire                    resp_ready_i
   );

  import uncore_pkg::*;

  localparam int unsigned sel_width_lp = $clog2(`UNCORE_CFG_REGS);

  word_t                   cfg_q [`UNCORE_CFG_REGS];
  logic [sel_width_lp-1:0] sel;
  logic                    cmd_fire, is_write;
  logic                    resp_v_q;
  word_t                   resp_data_q;

  // Registers are one word apart
  assign sel      = cmd_addr_i[3 +: sel_width_lp];
  assign cmd_fire = cmd_v_i & cmd_ready_o;
  assign is_write = (cmd_op_i == e_op_write);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < `UNCORE_CFG_REGS; i++)
        cfg_q[i] <= '0;
    end
    else if (cmd_fire & is_write)
    begin
      cfg_q[sel] <= cmd_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_q <= 1'b0;
    else if (cmd_fire)
      resp_v_q <= 1'b1;
    else if (resp_ready_i)
      resp_v_q <= 1'b0;
  end

  // Writes answer with zero
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
      resp_data_q <= is_write ? '0 : cfg_q[sel];
  end

  assign cmd_ready_o = ~resp_v_q;
  assign resp_v_o    = resp_v_q;
  assign resp_data_o = resp_data_q;

endmodule

`default_nettype wire

/* clint_slice.sv */
`default_nettype none

`include "uncore_config.svh"

module clint_slice
  (input  wire                      clk_i
   , input  wire                    reset_i

   , input  wire                    cmd_v_i
   , input  wire uncore_pkg::msg_op_e cmd_op_i
   , input  wire uncore_pkg::paddr_t  cmd_addr_i
   , input  wire uncore_pkg::word_t   cmd_data_i
   , output logic                   cmd_ready_o

   , output logic                   resp_v_o
   , output uncore_pkg::word_t      resp_data_o
   , input  wire                    resp_ready_i

   , output logic                   timer_irq_o
   , output logic                   software_irq_o
   );

  import uncore_pkg::*;

  logic [15:0] ofs;
  logic        cmd_fire, is_write;
  word_t       mtime_q, mtimecmp_q;
  logic        msip_q;
  word_t       rd_data;
  logic        resp_v_q;
  word_t       resp_data_q;

  assign ofs      = cmd_addr_i[15:0];
  assign cmd_fire = cmd_v_i & cmd_ready_o;
  assign is_write = (cmd_op_i == e_op_write);

  // Free running machine timer
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      mtime_q <= '0;
    else
      mtime_q <= mtime_q + 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end
    else if (cmd_fire & is_write)
    begin
      if (ofs == `UNCORE_CLINT_MTIMECMP_OFS)
        mtimecmp_q <= cmd_data_i;
      if (ofs == `UNCORE_CLINT_MSIP_OFS)
        msip_q <= cmd_data_i[0];
    end
  end

  always_comb
  begin
    case (ofs)
      `UNCORE_CLINT_MTIMECMP_OFS: rd_data = mtimecmp_q;
      `UNCORE_CLINT_MTIME_OFS:    rd_data = mtime_q;
      `UNCORE_CLINT_MSIP_OFS:     rd_data = word_t'(msip_q);
      default:                    rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_q <= 1'b0;
    else if (cmd_fire)
      resp_v_q <= 1'b1;
    else if (resp_ready_i)
      resp_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
      resp_data_q <= is_write ? '0 : rd_data;
  end

  assign cmd_ready_o    = ~resp_v_q;
  assign resp_v_o       = resp_v_q;
  assign resp_data_o    = resp_data_q;
  // Timer interrupt holds while mtime >= mtimecmp
  assign timer_irq_o    = ~(mtime_q < mtimecmp_q);
  assign software_irq_o = msip_q;

  a_mtime_monotonic: assert property (@(posedge clk_i) disable iff (reset_i)
    !$past(reset_i) |-> (mtime_q >= $past(mtime_q)))
    else $error("mtime went backwards");

endmodule

`default_nettype wire

/* cmd_decode.sv */
`default_nettype none

`include "uncore_config.svh"

module cmd_decode
  (input  wire                      clk_i
   , input  wire                    reset_i

   , input  wire                    cmd_v_i
   , input  wire uncore_pkg::msg_op_e cmd_op_i
   , input  wire uncore_pkg::paddr_t  cmd_addr_i
   , input  wire uncore_pkg::word_t   cmd_data_i
   , output logic                   cmd_ready_o

   , output logic                   cfg_v_o
   , input  wire                    cfg_ready_i
   , output logic                   clint_v_o
   , input  wire                    clint_ready_i
   , output logic                   mem_v_o
   , input  wire                    mem_ready_i
   , output logic                   io_v_o
   , input  wire                    io_ready_i
   , output logic                   loop_v_o
   , input  wire                    loop_ready_i
   , output uncore_pkg::msg_op_e    dev_op_o
   , output uncore_pkg::paddr_t     dev_addr_o
   , output uncore_pkg::word_t      dev_data_o

   , input  wire                    resp_done_i
   );

  import uncore_pkg::*;

  logic    cmd_v_q, cmd_v_n, cmd_ready_q, issue_q, pending_q;
  logic    cmd_fire, dev_fire, dst_ready;
  msg_op_e op_q;
  paddr_t  addr_q;
  word_t   data_q;
  dst_e    dst_q, dst_n;
  dev_id_t dev;
  logic    is_local, is_other_hio;
  logic    is_cfg, is_clint, is_io, is_mem, is_loop;

  assign cmd_fire = cmd_v_i & cmd_ready_o;

  // Decode from the registered address
  assign dev          = addr_q[`UNCORE_DEV_LSB +: `UNCORE_DEV_WIDTH];
  assign is_local     = (addr_q < `UNCORE_DRAM_BASE);
  assign is_other_hio = (addr_q[`UNCORE_PADDR_WIDTH-1 -: `UNCORE_HIO_WIDTH] != '0);
  assign is_cfg       = is_local & (dev == `UNCORE_CFG_DEV);
  assign is_clint     = is_local & (dev == `UNCORE_CLINT_DEV);
  assign is_io        = (is_local & ((dev == `UNCORE_BOOT_DEV) | (dev == `UNCORE_HOST_DEV)))
                        | is_other_hio;
  assign is_mem       = (~is_local & ~is_other_hio) | (is_local & (dev == `UNCORE_CACHE_DEV));
  assign is_loop      = is_local & ~is_cfg & ~is_clint & ~is_io & ~is_mem;

  always_comb
  begin
    dst_n = e_dst_loop;
    if (is_cfg)
      dst_n = e_dst_cfg;
    else if (is_clint)
      dst_n = e_dst_clint;
    else if (is_io)
      dst_n = e_dst_io;
    else if (is_mem)
      dst_n = e_dst_mem;
  end

  always_comb
  begin
    case (dst_q)
      e_dst_cfg:   dst_ready = cfg_ready_i;
      e_dst_clint: dst_ready = clint_ready_i;
      e_dst_io:    dst_ready = io_ready_i;
      e_dst_mem:   dst_ready = mem_ready_i;
      default:     dst_ready = loop_ready_i;
    endcase
  end

  assign dev_fire = issue_q & dst_ready;

  always_comb
  begin
    cmd_v_n = cmd_v_q;
    if (dev_fire)
      cmd_v_n = 1'b0;
    if (cmd_fire)
      cmd_v_n = 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      cmd_v_q     <= 1'b0;
      cmd_ready_q <= 1'b0;
      issue_q     <= 1'b0;
      pending_q   <= 1'b0;
    end
    else
    begin
      cmd_v_q     <= cmd_v_n;
      cmd_ready_q <= ~cmd_v_n;
      // Present to a device only once the previous response is delivered
      if (dev_fire)
        issue_q <= 1'b0;
      else if (cmd_v_q & ~issue_q & ~pending_q)
        issue_q <= 1'b1;
      if (dev_fire)
        pending_q <= 1'b1;
      else if (resp_done_i)
        pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      op_q   <= cmd_op_i;
      addr_q <= cmd_addr_i;
      data_q <= cmd_data_i;
    end
    if (cmd_v_q & ~issue_q & ~pending_q)
      dst_q <= dst_n;
  end

  assign cmd_ready_o = cmd_ready_q;
  assign cfg_v_o     = issue_q & (dst_q == e_dst_cfg);
  assign clint_v_o   = issue_q & (dst_q == e_dst_clint);
  assign io_v_o      = issue_q & (dst_q == e_dst_io);
  assign mem_v_o     = issue_q & (dst_q == e_dst_mem);
  assign loop_v_o    = issue_q & (dst_q == e_dst_loop);
  assign dev_op_o    = op_q;
  assign dev_addr_o  = addr_q;
  assign dev_data_o  = data_q;

  a_one_dst: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_q |-> $onehot({is_loop, is_mem, is_io, is_clint, is_cfg}))
    else $error("decode selected zero or several destinations");

  // One command past decode at a time
  a_no_issue_pending: assert property (@(posedge clk_i) disable iff (reset_i)
    pending_q |-> !(cfg_v_o | clint_v_o | mem_v_o | io_v_o | loop_v_o))
    else $error("device valid raised while a response is pending");

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
uncore_pkg.sv
cmd_decode.sv
cfg_regs.sv
clint_slice.sv
resp_return.sv
uncore_lite.sv
uncore_checker.sv
tb_uncore_lite.sv

/* resp_return.sv */
`default_nettype none

module resp_return
  (input  wire                      clk_i
   , input  wire                    reset_i

   , input  wire                    loop_v_i
   , output logic                   loop_ready_o

   , input  wire                    cfg_resp_v_i
   , input  wire uncore_pkg::word_t cfg_resp_data_i
   , output logic                   cfg_resp_ready_o
   , input  wire                    clint_resp_v_i
   , input  wire uncore_pkg::word_t clint_resp_data_i
   , output logic                   clint_resp_ready_o
   , input  wire                    mem_resp_v_i
   , input  wire uncore_pkg::word_t mem_resp_data_i
   , output logic                   mem_resp_ready_o
   , input  wire                    io_resp_v_i
   , input  wire uncore_pkg::word_t io_resp_data_i
   , output logic                   io_resp_ready_o

   , output logic                   resp_v_o
   , output uncore_pkg::word_t      resp_data_o
   , input  wire                    resp_ready_i
   , output logic                   resp_done_o
   );

  import uncore_pkg::*;

  logic  loop_full_q;
  logic  src_ready, src_v, take;
  word_t src_data;
  logic  resp_v_q;
  word_t resp_data_q;

  assign src_ready = ~resp_v_q | resp_ready_i;
  assign src_v     = cfg_resp_v_i | clint_resp_v_i | mem_resp_v_i | io_resp_v_i | loop_full_q;
  assign take      = src_ready & src_v;

  // Loopback slot answers with zero
  always_comb
  begin
    src_data = '0;
    if (cfg_resp_v_i)
      src_data = cfg_resp_data_i;
    else if (clint_resp_v_i)
      src_data = clint_resp_data_i;
    else if (mem_resp_v_i)
      src_data = mem_resp_data_i;
    else if (io_resp_v_i)
      src_data = io_resp_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      loop_full_q <= 1'b0;
      resp_v_q    <= 1'b0;
    end
    else
    begin
      if (loop_v_i & loop_ready_o)
        loop_full_q <= 1'b1;
      else if (loop_full_q & src_ready)
        loop_full_q <= 1'b0;
      if (take)
        resp_v_q <= 1'b1;
      else if (resp_ready_i)
        resp_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
      resp_data_q <= src_data;
  end

  assign loop_ready_o       = ~loop_full_q;
  assign cfg_resp_ready_o   = src_ready;
  assign clint_resp_ready_o = src_ready;
  assign mem_resp_ready_o   = src_ready;
  assign io_resp_ready_o    = src_ready;
  assign resp_v_o           = resp_v_q;
  assign resp_data_o        = resp_data_q;
  assign resp_done_o        = resp_v_q & resp_ready_i;

  a_one_source: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({cfg_resp_v_i, clint_resp_v_i, mem_resp_v_i, io_resp_v_i, loop_full_q}))
    else $error("more than one response source valid");

endmodule

`default_nettype wire

/* tb_uncore_lite.sv */
`default_nettype none

module tb_uncore_lite;

  import uncore_pkg::*;

  localparam int num_entries = 30;
  localparam int max_cycles  = 200 * num_entries;

  // Which external port an entry is expected to use
  localparam logic [1:0] port_none = 2'd0;
  localparam logic [1:0] port_mem  = 2'd1;
  localparam logic [1:0] port_io   = 2'd2;

  logic       clk_i, reset_i;
  logic       cmd_v_i, cmd_ready_o;
  msg_op_e    cmd_op_i;
  paddr_t     cmd_addr_i;
  word_t      cmd_data_i;
  logic       resp_v_o, resp_ready_i;
  word_t      resp_data_o;
  logic       mem_cmd_v_o, mem_cmd_ready_i, mem_resp_v_i, mem_resp_ready_o;
  msg_op_e    mem_cmd_op_o;
  paddr_t     mem_cmd_addr_o;
  word_t      mem_cmd_data_o, mem_resp_data_i;
  logic       io_cmd_v_o, io_cmd_ready_i, io_resp_v_i, io_resp_ready_o;
  msg_op_e    io_cmd_op_o;
  paddr_t     io_cmd_addr_o;
  word_t      io_cmd_data_o, io_resp_data_i;
  logic       timer_irq_o, software_irq_o;

  word_t      exp_data;
  logic [1:0] exp_port, exp_irq;
  int         error_count, cmd_count, resp_count;

  // The irq column holds {timer, software}
  msg_op_e    tab_op   [num_entries];
  paddr_t     tab_addr [num_entries];
  word_t      tab_data [num_entries];
  word_t      tab_exp  [num_entries];
  logic [1:0] tab_port [num_entries];
  logic [1:0] tab_irq  [num_entries];
  int         tab_len;
  int         cur_entry;
  int         cycles;

  // External memory and I/O responder
  word_t      ext_mem [16];
  logic       ext_busy, ext_show, ext_is_io;
  int         ext_delay, stall_left;
  word_t      ext_resp_data;
  integer     seed;

  uncore_lite uncore_lite_i (.*);

  uncore_checker checker_i
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_i(cmd_ready_o)
     ,.cmd_op_i(cmd_op_i)
     ,.cmd_addr_i(cmd_addr_i)
     ,.cmd_data_i(cmd_data_i)
     ,.resp_v_i(resp_v_o)
     ,.resp_data_i(resp_data_o)
     ,.resp_ready_i(resp_ready_i)
     ,.mem_cmd_v_i(mem_cmd_v_o)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.mem_cmd_op_i(mem_cmd_op_o)
     ,.mem_cmd_addr_i(mem_cmd_addr_o)
     ,.mem_cmd_data_i(mem_cmd_data_o)
     ,.io_cmd_v_i(io_cmd_v_o)
     ,.io_cmd_ready_i(io_cmd_ready_i)
     ,.io_cmd_op_i(io_cmd_op_o)
     ,.io_cmd_addr_i(io_cmd_addr_o)
     ,.io_cmd_data_i(io_cmd_data_o)
     ,.timer_irq_i(timer_irq_o)
     ,.software_irq_i(software_irq_o)
     ,.exp_data_i(exp_data)
     ,.exp_port_i(exp_port)
     ,.exp_irq_i(exp_irq)
     ,.error_count_o(error_count)
     ,.cmd_count_o(cmd_count)
     ,.resp_count_o(resp_count)
     );

  task automatic add_entry(input msg_op_e op, input paddr_t addr, input word_t data,
                           input word_t exp, input logic [1:0] port, input logic [1:0] irq);
    tab_op[tab_len]   = op;
    tab_addr[tab_len] = addr;
    tab_data[tab_len] = data;
    tab_exp[tab_len]  = exp;
    tab_port[tab_len] = port;
    tab_irq[tab_len]  = irq;
    tab_len++;
  endtask

  task automatic fill_table();
    tab_len = 0;
    // Address bits 4:3 pick the configuration register
    add_entry(e_op_write, 40'h00_0020_0000, 64'h1111_2222_3333_4444, '0, port_none, 2'b00);
    add_entry(e_op_write, 40'h00_0020_0008, 64'h5555_6666_7777_8888, '0, port_none, 2'b00);
    add_entry(e_op_write, 40'h00_0020_0010, 64'h0123_4567_89ab_cdef, '0, port_none, 2'b00);
    add_entry(e_op_write, 40'h00_0020_0018, 64'hfedc_ba98_7654_3210, '0, port_none, 2'b00);
    add_entry(e_op_read, 40'h00_0020_0000, '0, 64'h1111_2222_3333_4444, port_none, 2'b00);
    add_entry(e_op_read, 40'h00_0020_0008, '0, 64'h5555_6666_7777_8888, port_none, 2'b00);
    add_entry(e_op_read, 40'h00_0020_0010, '0, 64'h0123_4567_89ab_cdef, port_none, 2'b00);
    add_entry(e_op_read, 40'h00_0020_0018, '0, 64'hfedc_ba98_7654_3210, port_none, 2'b00);
    // DRAM and the cache device go to memory
    add_entry(e_op_write, 40'h00_8000_0100, 64'hcafe_f00d_0000_0001, '0, port_mem, 2'b00);
    add_entry(e_op_read, 40'h00_8000_0100, '0, 64'hcafe_f00d_0000_0001, port_mem, 2'b00);
    add_entry(e_op_write, 40'h00_0040_0018, 64'h0bad_beef_1234_5678, '0, port_mem, 2'b00);
    add_entry(e_op_read, 40'h00_0040_0018, '0, 64'h0bad_beef_1234_5678, port_mem, 2'b00);
    // Boot, host and other hio domains go to I/O
    add_entry(e_op_read, 40'h00_0000_1000, '0, ~64'h00_0000_1000, port_io, 2'b00);
    add_entry(e_op_read, 40'h00_0010_0040, '0, ~64'h00_0010_0040, port_io, 2'b00);
    add_entry(e_op_read, 40'h10_0000_0000, '0, ~64'h10_0000_0000, port_io, 2'b00);
    add_entry(e_op_write, 40'hf0_0000_0008, 64'h0000_0000_0000_0077, '0, port_io, 2'b00);
    // Unmapped local devices
    add_entry(e_op_read, 40'h00_0050_0000, '0, '0, port_none, 2'b00);
    add_entry(e_op_write, 40'h00_00f0_0008, 64'h0000_0000_0000_ffff, '0, port_none, 2'b00);
    add_entry(e_op_read, 40'h00_7ff0_0000, '0, '0, port_none, 2'b00);
    // CLINT msip, then mtimecmp
    add_entry(e_op_write, 40'h00_0030_0000, 64'h1, '0, port_none, 2'b01);
    add_entry(e_op_read, 40'h00_0030_0000, '0, 64'h1, port_none, 2'b01);
    add_entry(e_op_write, 40'h00_0030_0000, 64'h0, '0, port_none, 2'b00);
    add_entry(e_op_write, 40'h00_0030_4000, 64'h0, '0, port_none, 2'b10);
    add_entry(e_op_read, 40'h00_0030_4000, '0, 64'h0, port_none, 2'b10);
    add_entry(e_op_write, 40'h00_0030_4000, 64'h0123_4567_89ab_cdef, '0, port_none, 2'b00);
    add_entry(e_op_read, 40'h00_0030_4000, '0, 64'h0123_4567_89ab_cdef, port_none, 2'b00);
    add_entry(e_op_write, 40'h00_0030_4000, '1, '0, port_none, 2'b00);
    add_entry(e_op_read, 40'h00_0030_4000, '0, '1, port_none, 2'b00);
    add_entry(e_op_read, 40'h00_0020_0010, '0, 64'h0123_4567_89ab_cdef, port_none, 2'b00);
    add_entry(e_op_read, 40'h00_8000_0100, '0, 64'hcafe_f00d_0000_0001, port_mem, 2'b00);
  endtask

  // Called 2 time units after a rising edge
  task automatic send_command(input int idx);
    cmd_v_i    = 1'b1;
    cmd_op_i   = tab_op[idx];
    cmd_addr_i = tab_addr[idx];
    cmd_data_i = tab_data[idx];
    exp_data   = tab_exp[idx];
    exp_port   = tab_port[idx];
    exp_irq    = tab_irq[idx];
    @(posedge clk_i);
    while (!cmd_ready_o)
      @(posedge clk_i);
    #2;
    cmd_v_i = 1'b0;
  endtask

  task automatic wait_response(input int count);
    while (resp_count < count)
      @(posedge clk_i);
    #2;
  endtask

  task automatic accept_external(input logic is_io, input msg_op_e op, input paddr_t addr,
                                 input word_t data);
    ext_busy  = 1'b1;
    ext_show  = 1'b0;
    ext_is_io = is_io;
    ext_delay = $random(seed) & 7;
    if (is_io)
      ext_resp_data = (op == e_op_read) ? ~word_t'(addr) : '0;
    else if (op == e_op_write)
    begin
      ext_mem[addr[6:3]] = data;
      ext_resp_data      = '0;
    end
    else
      ext_resp_data = ext_mem[addr[6:3]];
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever
      #10 clk_i = ~clk_i;
  end

  initial
  begin
    cycles = 0;
    forever
    begin
      @(posedge clk_i);
      cycles++;
      if (cycles >= max_cycles)
      begin
        $display("Timeout after %0d cycles, table entry %0d never completed", cycles, cur_entry);
        $display("TESTBENCH FAILED");
        $finish;
      end
    end
  end

  // Random back-pressure and the external responder
  initial
  begin : environment
    seed            = 32'ha74b_1077;
    resp_ready_i    = 1'b0;
    mem_cmd_ready_i = 1'b0;
    io_cmd_ready_i  = 1'b0;
    mem_resp_v_i    = 1'b0;
    mem_resp_data_i = '0;
    io_resp_v_i     = 1'b0;
    io_resp_data_i  = '0;
    ext_busy        = 1'b0;
    ext_show        = 1'b0;
    ext_is_io       = 1'b0;
    ext_delay       = 0;
    stall_left      = 0;
    ext_resp_data   = '0;
    for (int i = 0; i < 16; i++)
      ext_mem[i] = 64'hc0de_0000_0000_0000 | word_t'(i);
    @(negedge reset_i);
    forever
    begin
      @(posedge clk_i);
      if (ext_show && (ext_is_io ? io_resp_ready_o : mem_resp_ready_o))
      begin
        ext_show = 1'b0;
        ext_busy = 1'b0;
      end
      else if (ext_busy && !ext_show)
      begin
        if (ext_delay == 0)
          ext_show = 1'b1;
        else
          ext_delay--;
      end
      else if (!ext_busy && mem_cmd_v_o && mem_cmd_ready_i)
        accept_external(1'b0, mem_cmd_op_o, mem_cmd_addr_o, mem_cmd_data_o);
      else if (!ext_busy && io_cmd_v_o && io_cmd_ready_i)
        accept_external(1'b1, io_cmd_op_o, io_cmd_addr_o, io_cmd_data_o);
      // Occasional bursts of six stalled cycles
      if (stall_left > 0)
        stall_left--;
      else if (($random(seed) & 15) == 0)
        stall_left = 6;
      #2;
      resp_ready_i    = (stall_left == 0) && (($random(seed) & 3) != 0);
      mem_cmd_ready_i = !ext_busy && (($random(seed) & 1) != 0);
      io_cmd_ready_i  = !ext_busy && (($random(seed) & 1) != 0);
      mem_resp_v_i    = ext_show && !ext_is_io;
      io_resp_v_i     = ext_show && ext_is_io;
      mem_resp_data_i = ext_resp_data;
      io_resp_data_i  = ext_resp_data;
    end
  end

  initial
  begin : run_table
    int tb_errors;
    tb_errors  = 0;
    cur_entry  = 0;
    reset_i    = 1'b1;
    cmd_v_i    = 1'b0;
    cmd_op_i   = e_op_read;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    exp_data   = '0;
    exp_port   = port_none;
    exp_irq    = 2'b00;
    fill_table();
    repeat (8) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    for (int i = 0; i < tab_len; i++)
    begin
      cur_entry = i;
      send_command(i);
      wait_response(i + 1);
    end
    repeat (4) @(posedge clk_i);
    if ((cmd_count != tab_len) || (resp_count != tab_len))
    begin
      $display("Responses lost or duplicated: %0d entries, %0d commands, %0d responses",
               tab_len, cmd_count, resp_count);
      tb_errors++;
    end
    $display("Run complete: %0d entries, %0d commands, %0d responses, %0d errors",
             tab_len, cmd_count, resp_count, error_count + tb_errors);
    if ((error_count + tb_errors) == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* uncore_checker.sv */
`default_nettype none

module uncore_checker
  (input  wire                        clk_i
   , input  wire                      reset_i

   , input  wire                      cmd_v_i
   , input  wire                      cmd_ready_i
   , input  wire uncore_pkg::msg_op_e cmd_op_i
   , input  wire uncore_pkg::paddr_t  cmd_addr_i
   , input  wire uncore_pkg::word_t   cmd_data_i
   , input  wire                      resp_v_i
   , input  wire uncore_pkg::word_t   resp_data_i
   , input  wire                      resp_ready_i

   , input  wire                      mem_cmd_v_i
   , input  wire                      mem_cmd_ready_i
   , input  wire uncore_pkg::msg_op_e mem_cmd_op_i
   , input  wire uncore_pkg::paddr_t  mem_cmd_addr_i
   , input  wire uncore_pkg::word_t   mem_cmd_data_i
   , input  wire                      io_cmd_v_i
   , input  wire                      io_cmd_ready_i
   , input  wire uncore_pkg::msg_op_e io_cmd_op_i
   , input  wire uncore_pkg::paddr_t  io_cmd_addr_i
   , input  wire uncore_pkg::word_t   io_cmd_data_i

   , input  wire                      timer_irq_i
   , input  wire                      software_irq_i

   , input  wire uncore_pkg::word_t   exp_data_i
   , input  wire [1:0]                exp_port_i
   , input  wire [1:0]                exp_irq_i

   , output int                       error_count_o
   , output int                       cmd_count_o
   , output int                       resp_count_o
   );

  import uncore_pkg::*;

  localparam logic [1:0] port_none = 2'd0;
  localparam logic [1:0] port_mem  = 2'd1;
  localparam logic [1:0] port_io   = 2'd2;

  int         errors, cmds, resps;
  logic       busy, ext_seen, held_v;
  msg_op_e    cur_op;
  paddr_t     cur_addr;
  word_t      cur_data, cur_exp, held_data;
  logic [1:0] cur_port, cur_irq;

  task automatic compare_word(input string name, input word_t exp, input word_t act);
    if (exp !== act)
    begin
      $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic report(input string what);
    $display("Check failed at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic check_external(input logic [1:0] port, input string name,
                                input msg_op_e op, input paddr_t addr, input word_t data);
    if (!busy || (cur_port != port))
      report($sformatf("%s accepted a command that does not belong on this port", name));
    else
    begin
      compare_word($sformatf("%s_op_o", name), word_t'(cur_op), word_t'(op));
      compare_word($sformatf("%s_addr_o", name), word_t'(cur_addr), word_t'(addr));
      compare_word($sformatf("%s_data_o", name), cur_data, data);
      if (ext_seen)
        report($sformatf("%s carried the same command twice", name));
      ext_seen = 1'b1;
    end
  endtask

  task automatic check_response();
    if (!busy)
      report("a response came back with no command outstanding");
    else
    begin
      compare_word("resp_data_o", cur_exp, resp_data_i);
      compare_word("timer_irq_o", word_t'(cur_irq[1]), word_t'(timer_irq_i));
      compare_word("software_irq_o", word_t'(cur_irq[0]), word_t'(software_irq_i));
      if ((cur_port != port_none) && !ext_seen)
        report("a response came back without a command on the external port");
    end
    busy = 1'b0;
    resps++;
  endtask

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      errors   = 0;
      cmds     = 0;
      resps    = 0;
      busy     = 1'b0;
      ext_seen = 1'b0;
      held_v   = 1'b0;
    end
    else
    begin
      // A stalled response keeps its valid and data
      if (held_v)
      begin
        if (!resp_v_i)
          report("resp_v_o dropped while resp_ready_i was low");
        else
          compare_word("resp_data_o", held_data, resp_data_i);
      end
      held_v    = resp_v_i & ~resp_ready_i;
      held_data = resp_data_i;
      if (mem_cmd_v_i && mem_cmd_ready_i)
        check_external(port_mem, "mem_cmd", mem_cmd_op_i, mem_cmd_addr_i, mem_cmd_data_i);
      if (io_cmd_v_i && io_cmd_ready_i)
        check_external(port_io, "io_cmd", io_cmd_op_i, io_cmd_addr_i, io_cmd_data_i);
      if (resp_v_i && resp_ready_i)
        check_response();
      if (cmd_v_i && cmd_ready_i)
      begin
        if (busy)
          report("a command was accepted while another was outstanding");
        busy     = 1'b1;
        ext_seen = 1'b0;
        cur_op   = cmd_op_i;
        cur_addr = cmd_addr_i;
        cur_data = cmd_data_i;
        cur_exp  = exp_data_i;
        cur_port = exp_port_i;
        cur_irq  = exp_irq_i;
        cmds++;
      end
    end
    error_count_o <= errors;
    cmd_count_o   <= cmds;
    resp_count_o  <= resps;
  end

endmodule

`default_nettype wire

/* uncore_config.svh */
`ifndef UNCORE_CONFIG_SVH
`define UNCORE_CONFIG_SVH

// Physical address and data word
`define UNCORE_PADDR_WIDTH 40
`define UNCORE_DATA_WIDTH  64

// Everything below this address is local to the tile
`define UNCORE_DRAM_BASE 40'h00_8000_0000

// Top address bits that select another host I/O domain
`define UNCORE_HIO_WIDTH 4

// Device field of a local address sits in bits 23:20
`define UNCORE_DEV_LSB   20
`define UNCORE_DEV_WIDTH 4

`define UNCORE_BOOT_DEV  4'd0
`define UNCORE_HOST_DEV  4'd1
`define UNCORE_CFG_DEV   4'd2
`define UNCORE_CLINT_DEV 4'd3
`define UNCORE_CACHE_DEV 4'd4

`define UNCORE_CFG_REGS 4

// CLINT register offsets within address bits 15:0
`define UNCORE_CLINT_MSIP_OFS     16'h0000
`define UNCORE_CLINT_MTIMECMP_OFS 16'h4000
`define UNCORE_CLINT_MTIME_OFS    16'hbff8

`endif

/* uncore_lite.sv */
`default_nettype none

module uncore_lite
  (input  wire                        clk_i
   , input  wire                      reset_i

   , input  wire                      cmd_v_i
   , input  wire uncore_pkg::msg_op_e cmd_op_i
   , input  wire uncore_pkg::paddr_t  cmd_addr_i
   , input  wire uncore_pkg::word_t   cmd_data_i
   , output logic                     cmd_ready_o

   , output logic                     resp_v_o
   , output uncore_pkg::word_t        resp_data_o
   , input  wire                      resp_ready_i

   , output logic                     mem_cmd_v_o
   , output uncore_pkg::msg_op_e      mem_cmd_op_o
   , output uncore_pkg::paddr_t       mem_cmd_addr_o
   , output uncore_pkg::word_t        mem_cmd_data_o
   , input  wire                      mem_cmd_ready_i
   , input  wire                      mem_resp_v_i
   , input  wire uncore_pkg::word_t   mem_resp_data_i
   , output logic                     mem_resp_ready_o

   , output logic                     io_cmd_v_o
   , output uncore_pkg::msg_op_e      io_cmd_op_o
   , output uncore_pkg::paddr_t       io_cmd_addr_o
   , output uncore_pkg::word_t        io_cmd_data_o
   , input  wire                      io_cmd_ready_i
   , input  wire                      io_resp_v_i
   , input  wire uncore_pkg::word_t   io_resp_data_i
   , output logic                     io_resp_ready_o

   , output logic                     timer_irq_o
   , output logic                     software_irq_o
   );

  import uncore_pkg::*;

  msg_op_e dev_op;
  paddr_t  dev_addr;
  word_t   dev_data;
  logic    cfg_v, cfg_ready, clint_v, clint_ready, loop_v, loop_ready;
  logic    cfg_resp_v, cfg_resp_ready, clint_resp_v, clint_resp_ready;
  word_t   cfg_resp_data, clint_resp_data;
  logic    resp_done;

  cmd_decode decode
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_op_i(cmd_op_i)
     ,.cmd_addr_i(cmd_addr_i)
     ,.cmd_data_i(cmd_data_i)
     ,.cmd_ready_o(cmd_ready_o)
     ,.cfg_v_o(cfg_v)
     ,.cfg_ready_i(cfg_ready)
     ,.clint_v_o(clint_v)
     ,.clint_ready_i(clint_ready)
     ,.mem_v_o(mem_cmd_v_o)
     ,.mem_ready_i(mem_cmd_ready_i)
     ,.io_v_o(io_cmd_v_o)
     ,.io_ready_i(io_cmd_ready_i)
     ,.loop_v_o(loop_v)
     ,.loop_ready_i(loop_ready)
     ,.dev_op_o(dev_op)
     ,.dev_addr_o(dev_addr)
     ,.dev_data_o(dev_data)
     ,.resp_done_i(resp_done)
     );

  // External ports share the registered command
  assign mem_cmd_op_o   = dev_op;
  assign mem_cmd_addr_o = dev_addr;
  assign mem_cmd_data_o = dev_data;
  assign io_cmd_op_o    = dev_op;
  assign io_cmd_addr_o  = dev_addr;
  assign io_cmd_data_o  = dev_data;

  cfg_regs cfg
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_v_i(cfg_v)
     ,.cmd_op_i(dev_op)
     ,.cmd_addr_i(dev_addr)
     ,.cmd_data_i(dev_data)
     ,.cmd_ready_o(cfg_ready)
     ,.resp_v_o(cfg_resp_v)
     ,.resp_data_o(cfg_resp_data)
     ,.resp_ready_i(cfg_resp_ready)
     );

  clint_slice clint
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_v_i(clint_v)
     ,.cmd_op_i(dev_op)
     ,.cmd_addr_i(dev_addr)
     ,.cmd_data_i(dev_data)
     ,.cmd_ready_o(clint_ready)
     ,.resp_v_o(clint_resp_v)
     ,.resp_data_o(clint_resp_data)
     ,.resp_ready_i(clint_resp_ready)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  resp_return ret
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.loop_v_i(loop_v)
     ,.loop_ready_o(loop_ready)
     ,.cfg_resp_v_i(cfg_resp_v)
     ,.cfg_resp_data_i(cfg_resp_data)
     ,.cfg_resp_ready_o(cfg_resp_ready)
     ,.clint_resp_v_i(clint_resp_v)
     ,.clint_resp_data_i(clint_resp_data)
     ,.clint_resp_ready_o(clint_resp_ready)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_data_i(mem_resp_data_i)
     ,.mem_resp_ready_o(mem_resp_ready_o)
     ,.io_resp_v_i(io_resp_v_i)
     ,.io_resp_data_i(io_resp_data_i)
     ,.io_resp_ready_o(io_resp_ready_o)
     ,.resp_v_o(resp_v_o)
     ,.resp_data_o(resp_data_o)
     ,.resp_ready_i(resp_ready_i)
     ,.resp_done_o(resp_done)
     );

endmodule

`default_nettype wire

/* uncore_pkg.sv */
`default_nettype none

`include "uncore_config.svh"

package uncore_pkg;

  typedef logic [`UNCORE_PADDR_WIDTH-1:0] paddr_t;
  typedef logic [`UNCORE_DATA_WIDTH-1:0]  word_t;
  typedef logic [`UNCORE_DEV_WIDTH-1:0]   dev_id_t;

  typedef enum logic
  {
    e_op_read  = 1'b0,
    e_op_write = 1'b1
  } msg_op_e;

  // Where a processor command goes
  typedef enum logic [2:0]
  {
    e_dst_cfg   = 3'd0,
    e_dst_clint = 3'd1,
    e_dst_io    = 3'd2,
    e_dst_mem   = 3'd3,
    e_dst_loop  = 3'd4
  } dst_e;

endpackage

`default_nettype wire
